//--- sources.f
+incdir+logic
logic/mips_pkg.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_decoder.sv
logic/mips_control.sv
logic/mips_cpu_bus.sv
verification/avalon_mem_model.sv
verification/mips_cpu_bus_sva.sv
verification/mips_cpu_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
    --top-module mips_cpu_bus_tb -o sim_mips_cpu_bus

./obj_dir/sim_mips_cpu_bus > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    exit 0
fi
exit 1

//--- verification/mips_cpu_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus_tb;

    typedef enum int {
        K_ADDU, K_SUBU, K_AND, K_OR, K_XOR, K_SLT, K_SLTU, K_SLL, K_SRL, K_SRA,
        K_ADDIU, K_SLTI, K_SLTIU, K_ANDI, K_ORI, K_XORI, K_LUI, K_MEM, K_BEQ, K_BNE, K_J
    } kind_e;

    typedef struct {
        string       name;
        kind_e       kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
    } test_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        stall_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;
    int          bad_byteenable;

    test_t       tests[$];
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000000;
    integer      seed = 97635;

    mips_cpu_bus u_dut (.*);

    avalon_mem_model u_mem (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the CPU did not halt within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] rtype(int rs, int rt, int rd, int sh, int fn);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic logic [31:0] itype(int op, int rs, int rt, logic [15:0] imm);
        return {6'(op), 5'(rs), 5'(rt), imm};
    endfunction

    // Expected $v0 from the MIPS-I rules
    function automatic logic [31:0] reference_result(kind_e k, logic [31:0] a, logic [31:0] b);
        logic [31:0] se;
        logic [31:0] ze;
        se = {{16{b[15]}}, b[15:0]};
        ze = {16'h0000, b[15:0]};
        case (k)
            K_ADDU:  return a + b;
            K_SUBU:  return a - b;
            K_AND:   return a & b;
            K_OR:    return a | b;
            K_XOR:   return a ^ b;
            K_SLT:   return {31'd0, $signed(a) < $signed(b)};
            K_SLTU:  return {31'd0, a < b};
            K_SLL:   return b << a[4:0];
            K_SRL:   return b >> a[4:0];
            K_SRA:   return $signed(b) >>> a[4:0];
            K_ADDIU: return a + se;
            K_SLTI:  return {31'd0, $signed(a) < $signed(se)};
            K_SLTIU: return {31'd0, a < se};
            K_ANDI:  return a & ze;
            K_ORI:   return a | ze;
            K_XORI:  return a ^ ze;
            K_LUI:   return {b[15:0], 16'h0000};
            K_MEM:   return a;
            K_BEQ:   return (a == b) ? 32'h10 : 32'h11;
            K_BNE:   return (a != b) ? 32'h10 : 32'h11;
            default: return 32'h10;
        endcase
    endfunction

    task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_test(string name, kind_e kind, logic [31:0] a, logic [31:0] b);
        test_t t;
        t.name = name;
        t.kind = kind;
        t.a = a;
        t.b = b;
        t.expected = reference_result(kind, a, b);
        tests.push_back(t);
    endtask

    // Program at the reset vector, operands at BFC00100
    task automatic load_program(test_t t);
        logic [31:0] prog [16];
        int          fn;
        int          op;
        for (int i = 0; i < 16; i++) begin
            prog[i] = 32'h0;
        end
        prog[0] = itype(15, 0, 8, 16'hBFC0);
        prog[1] = itype(13, 8, 8, 16'h0100);
        prog[2] = itype(35, 8, 4, 16'h0000);
        prog[3] = itype(35, 8, 5, 16'h0004);
        prog[5] = rtype(0, 0, 0, 0, 8);
        case (t.kind)
            K_ADDU, K_SUBU, K_AND, K_OR, K_XOR, K_SLT, K_SLTU: begin
                fn = (t.kind == K_ADDU) ? 33 : (t.kind == K_SUBU) ? 35 :
                     (t.kind == K_AND) ? 36 : (t.kind == K_OR) ? 37 :
                     (t.kind == K_XOR) ? 38 : (t.kind == K_SLT) ? 42 : 43;
                prog[4] = rtype(4, 5, 2, 0, fn);
            end
            K_SLL, K_SRL, K_SRA: begin
                fn = (t.kind == K_SLL) ? 0 : (t.kind == K_SRL) ? 2 : 3;
                prog[4] = rtype(0, 5, 2, int'(t.a[4:0]), fn);
            end
            K_ADDIU, K_SLTI, K_SLTIU, K_ANDI, K_ORI, K_XORI: begin
                op = (t.kind == K_ADDIU) ? 9 : (t.kind == K_SLTI) ? 10 :
                     (t.kind == K_SLTIU) ? 11 : (t.kind == K_ANDI) ? 12 :
                     (t.kind == K_ORI) ? 13 : 14;
                prog[4] = itype(op, 4, 2, t.b[15:0]);
            end
            K_LUI: begin
                prog[4] = rtype(4, 0, 2, 0, 33);
                prog[5] = itype(15, 0, 2, t.b[15:0]);
                prog[6] = rtype(0, 0, 0, 0, 8);
            end
            K_MEM: begin
                prog[4] = itype(43, 8, 4, 16'h0008);
                prog[5] = itype(35, 8, 2, 16'h0008);
                // Write to $zero, then fold $zero into $v0
                prog[6] = itype(9, 0, 0, 16'h0005);
                prog[7] = rtype(2, 0, 2, 0, 33);
                prog[8] = rtype(0, 0, 0, 0, 8);
            end
            default: begin
                prog[4] = itype(9, 0, 2, 16'h0010);
                if (t.kind == K_J) begin
                    prog[5] = {6'd2, 26'((32'hBFC0_0000 + 32'd28) >> 2)};
                end else begin
                    prog[5] = itype((t.kind == K_BEQ) ? 4 : 5, 4, 5, 16'h0001);
                end
                prog[6] = itype(9, 2, 2, 16'h0001);
                prog[7] = rtype(0, 0, 0, 0, 8);
            end
        endcase
        for (int i = 0; i < 256; i++) begin
            u_mem.mem[i] <= (i < 16) ? prog[i] : 32'h0;
        end
        u_mem.mem[64] <= t.a;
        u_mem.mem[65] <= t.b;
    endtask

    task automatic run_test(test_t t, string tag);
        @(posedge clk);
        reset <= 1'b1;
        load_program(t);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        while (active !== 1'b0) begin
            @(negedge clk);
        end
        compare({t.name, tag}, t.expected, register_v0);
        if (t.kind == K_MEM) begin
            compare({t.name, tag, " store"}, t.a, u_mem.mem[66]);
        end
        // Stays halted with no bus traffic
        repeat (4) begin
            @(negedge clk);
            compare({t.name, tag, " halt"}, 32'h0, {29'd0, active, read, write});
        end
    endtask

    initial begin
        reset <= 1'b1;
        stall_enable <= 1'b0;
        add_test("addu", K_ADDU, 32'd100, 32'd23);
        add_test("subu", K_SUBU, 32'd5, 32'd9);
        add_test("and", K_AND, 32'hF0F0_1234, 32'h0FF0_FF00);
        add_test("or", K_OR, 32'hF000_0001, 32'h0000_8010);
        add_test("xor", K_XOR, 32'hAAAA_5555, 32'hFFFF_0000);
        add_test("slt_neg", K_SLT, 32'hFFFF_FFFF, 32'd1);
        add_test("sltu_neg", K_SLTU, 32'hFFFF_FFFF, 32'd1);
        add_test("sll", K_SLL, 32'd4, 32'h8000_0F01);
        add_test("srl_neg", K_SRL, 32'd4, 32'h8000_0000);
        add_test("sra_neg", K_SRA, 32'd4, 32'h8000_0000);
        add_test("addiu_neg", K_ADDIU, 32'd100, 32'h0000_FFF0);
        add_test("slti", K_SLTI, 32'd5, 32'h0000_FFFF);
        add_test("sltiu", K_SLTIU, 32'h0001_0000, 32'h0000_FFFF);
        add_test("andi", K_ANDI, 32'hFFFF_FFFF, 32'h0000_F0F0);
        add_test("ori", K_ORI, 32'h1234_0000, 32'h0000_8001);
        add_test("xori", K_XORI, 32'hFFFF_FFFF, 32'h0000_FFFF);
        add_test("lui", K_LUI, 32'h0000_ABCD, 32'h0000_8765);
        add_test("lw_sw", K_MEM, 32'hDEAD_BEEF, 32'd0);
        add_test("beq_taken", K_BEQ, 32'd7, 32'd7);
        add_test("beq_not", K_BEQ, 32'd7, 32'd8);
        add_test("bne_taken", K_BNE, 32'd7, 32'd8);
        add_test("bne_not", K_BNE, 32'd7, 32'd7);
        add_test("j", K_J, 32'd0, 32'd0);
        add_test("addu_rand", K_ADDU, $random(seed), $random(seed));
        add_test("slt_rand", K_SLT, $random(seed), $random(seed));
        add_test("sra_rand", K_SRA, $random(seed), $random(seed));
        cycle_limit = 2 * tests.size() * 12 * (3 + 4) * 2;
        for (int pass = 0; pass < 2; pass++) begin
            @(posedge clk);
            stall_enable <= (pass == 1);
            foreach (tests[i]) begin
                run_test(tests[i], (pass == 1) ? " stalled" : "");
            end
        end
        compare("byteenable", 32'h0, 32'(bad_byteenable));
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/mips_cpu_bus_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus_sva (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        active,
    input wire logic        read,
    input wire logic        write,
    input wire logic        waitrequest,
    input wire logic [31:0] address,
    input wire logic [31:0] writedata
);

    // Request held steady while the slave stalls
    read_hold: assert property (@(posedge clk) disable iff (reset)
        (read && waitrequest) |=> (read && $stable(address)))
        else $error("read or address changed during a stall");

    write_hold: assert property (@(posedge clk) disable iff (reset)
        (write && waitrequest) |=> (write && $stable(address) && $stable(writedata)))
        else $error("write, address or data changed during a stall");

    no_read_write: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write high together");

    reset_idle: assert property (@(posedge clk) reset |-> (!read && !write))
        else $error("bus strobe high during reset");

    after_reset: assert property (@(posedge clk) reset |=> active)
        else $error("core not active right after reset");

endmodule

bind mips_cpu_bus mips_cpu_bus_sva u_sva (.*);

`default_nettype wire

//--- verification/avalon_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module avalon_mem_model (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        stall_enable,
    input  wire logic [31:0] address,
    input  wire logic        read,
    input  wire logic        write,
    input  wire logic [31:0] writedata,
    input  wire logic [3:0]  byteenable,
    output logic      [31:0] readdata,
    output logic             waitrequest,
    output int               bad_byteenable
);

    // 256 words, decoded from address bits 9:2
    logic [31:0] mem [256];
    logic [1:0]  stall_left;
    integer      seed = 97635;

    // Zero read latency
    assign readdata    = mem[address[9:2]];
    assign waitrequest = (read || write) && (stall_left != 2'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_left <= 2'd0;
        end else if (read || write) begin
            if (stall_left != 2'd0) begin
                stall_left <= stall_left - 2'd1;
            end else if (stall_enable) begin
                // Stalls for the next request, 0 to 3 cycles
                stall_left <= 2'($random(seed) & 3);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset && write && !waitrequest) begin
            mem[address[9:2]] <= writedata;
            if (byteenable != 4'b1111) begin
                bad_byteenable <= bad_byteenable + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mips_cpu_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module mips_cpu_bus (
    input  wire logic        clk,
    input  wire logic        reset,
    output logic             active,
    output logic [31:0]      register_v0,

    // Avalon master
    output logic [31:0]      address,
    output logic             write,
    output logic             read,
    input  wire logic        waitrequest,
    output logic [31:0]      writedata,
    output logic [3:0]       byteenable,
    input  wire logic [31:0] readdata
);

    logic [`MIPS_XLEN-1:0]    instr;
    logic [`MIPS_RADDR_W-1:0] rs;
    logic [`MIPS_RADDR_W-1:0] rt;
    logic [`MIPS_RADDR_W-1:0] dest;
    logic [4:0]               shamt;
    mips_pkg::alu_op_t        alu_op;
    logic                     use_imm;
    logic [`MIPS_XLEN-1:0]    imm;
    logic                     writes_reg;
    logic                     is_load;
    logic                     is_store;
    logic                     is_beq;
    logic                     is_bne;
    logic                     is_j;
    logic                     is_jr;
    logic [25:0]              jump_index;
    logic [`MIPS_XLEN-1:0]    ra_data;
    logic [`MIPS_XLEN-1:0]    rb_data;
    logic [`MIPS_XLEN-1:0]    alu_b;
    logic [`MIPS_XLEN-1:0]    alu_result;
    logic                     equal;
    logic                     reg_we;
    logic                     wb_from_mem;
    logic [`MIPS_XLEN-1:0]    wr_data;

    assign alu_b   = use_imm ? imm : rb_data;
    assign wr_data = wb_from_mem ? readdata : alu_result;

    // Word accesses only
    assign writedata  = rb_data;
    assign byteenable = 4'b1111;

    mips_control u_control (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .writes_reg  (writes_reg),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_beq      (is_beq),
        .is_bne      (is_bne),
        .is_j        (is_j),
        .is_jr       (is_jr),
        .jump_index  (jump_index),
        .imm         (imm),
        .alu_result  (alu_result),
        .equal       (equal),
        .rs_value    (ra_data),
        .instr       (instr),
        .address     (address),
        .read        (read),
        .write       (write),
        .active      (active),
        .reg_we      (reg_we),
        .wb_from_mem (wb_from_mem)
    );

    mips_decoder u_decoder (
        .instr      (instr),
        .rs         (rs),
        .rt         (rt),
        .dest       (dest),
        .shamt      (shamt),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .imm        (imm),
        .writes_reg (writes_reg),
        .is_load    (is_load),
        .is_store   (is_store),
        .is_beq     (is_beq),
        .is_bne     (is_bne),
        .is_j       (is_j),
        .is_jr      (is_jr),
        .jump_index (jump_index)
    );

    mips_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .ra_addr (rs),
        .rb_addr (rt),
        .wr_addr (dest),
        .we      (reg_we),
        .wr_data (wr_data),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .v0      (register_v0)
    );

    mips_alu u_alu (
        .op     (alu_op),
        .a      (ra_data),
        .b      (alu_b),
        .shamt  (shamt),
        .result (alu_result),
        .equal  (equal)
    );

endmodule

`default_nettype wire

//--- logic/mips_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module mips_control (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  waitrequest,
    input  wire logic [`MIPS_XLEN-1:0] readdata,
    input  wire logic                  writes_reg,
    input  wire logic                  is_load,
    input  wire logic                  is_store,
    input  wire logic                  is_beq,
    input  wire logic                  is_bne,
    input  wire logic                  is_j,
    input  wire logic                  is_jr,
    input  wire logic [25:0]           jump_index,
    input  wire logic [`MIPS_XLEN-1:0] imm,
    input  wire logic [`MIPS_XLEN-1:0] alu_result,
    input  wire logic                  equal,
    input  wire logic [`MIPS_XLEN-1:0] rs_value,
    output logic      [`MIPS_XLEN-1:0] instr,
    output logic      [`MIPS_XLEN-1:0] address,
    output logic                       read,
    output logic                       write,
    output logic                       active,
    output logic                       reg_we,
    output logic                       wb_from_mem
);

    mips_pkg::state_t      state;
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] ir;
    logic [`MIPS_XLEN-1:0] ea;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] pc_next;
    logic                  branch_taken;

    assign pc_plus4     = pc + 32'd4;
    assign branch_taken = (is_beq && equal) || (is_bne && !equal);

    // Next PC for the instruction now in EXEC1, no delay slot
    always_comb begin
        if (is_jr) begin
            pc_next = rs_value;
        end else if (is_j) begin
            pc_next = {pc_plus4[31:28], jump_index, 2'b00};
        end else if (branch_taken) begin
            pc_next = pc_plus4 + {imm[`MIPS_XLEN-3:0], 2'b00};
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= mips_pkg::FETCH;
            pc     <= `MIPS_RESET_VECTOR;
            ir     <= '0;
            active <= 1'b1;
        end else begin
            case (state)
                mips_pkg::FETCH: begin
                    if (!waitrequest) begin
                        ir    <= readdata;
                        state <= mips_pkg::EXEC1;
                    end
                end
                mips_pkg::EXEC1: begin
                    if (is_load || is_store) begin
                        state <= mips_pkg::EXEC2;
                    end else begin
                        pc <= pc_next;
                        if (pc_next == `MIPS_HALT_ADDR) begin
                            state  <= mips_pkg::HALT;
                            active <= 1'b0;
                        end else begin
                            state <= mips_pkg::FETCH;
                        end
                    end
                end
                mips_pkg::EXEC2: begin
                    if (!waitrequest) begin
                        pc    <= pc_plus4;
                        state <= mips_pkg::FETCH;
                    end
                end
                default: begin
                    // Parked until reset
                end
            endcase
        end
    end

    // Data address, latched so it holds through stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            ea <= '0;
        end else if (state == mips_pkg::EXEC1 && (is_load || is_store)) begin
            ea <= alu_result;
        end
    end

    assign instr   = ir;
    assign address = (state == mips_pkg::EXEC2) ? ea : pc;

    // Strobes from registered state, held low in reset
    assign read  = !reset
                && ((state == mips_pkg::FETCH) || (state == mips_pkg::EXEC2 && is_load));
    assign write = !reset && (state == mips_pkg::EXEC2) && is_store;

    assign wb_from_mem = (state == mips_pkg::EXEC2);
    assign reg_we = (state == mips_pkg::EXEC1 && writes_reg)
                 || (state == mips_pkg::EXEC2 && is_load && !waitrequest);

endmodule

`default_nettype wire

//--- logic/mips_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module mips_decoder (
    input  wire logic [`MIPS_XLEN-1:0]    instr,
    output logic      [`MIPS_RADDR_W-1:0] rs,
    output logic      [`MIPS_RADDR_W-1:0] rt,
    output logic      [`MIPS_RADDR_W-1:0] dest,
    output logic      [4:0]               shamt,
    output mips_pkg::alu_op_t             alu_op,
    output logic                          use_imm,
    output logic      [`MIPS_XLEN-1:0]    imm,
    output logic                          writes_reg,
    output logic                          is_load,
    output logic                          is_store,
    output logic                          is_beq,
    output logic                          is_bne,
    output logic                          is_j,
    output logic                          is_jr,
    output logic      [25:0]              jump_index
);

    mips_pkg::opcode_t     opcode;
    mips_pkg::funct_t      funct;
    logic [`MIPS_XLEN-1:0] imm_sext;
    logic [`MIPS_XLEN-1:0] imm_zext;

    assign opcode = mips_pkg::opcode_t'(instr[31:26]);
    assign funct  = mips_pkg::funct_t'(instr[5:0]);

    assign rs         = instr[25:21];
    assign rt         = instr[20:16];
    assign shamt      = instr[10:6];
    assign jump_index = instr[25:0];

    assign imm_sext = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};
    assign imm_zext = {{(`MIPS_XLEN-16){1'b0}}, instr[15:0]};

    always_comb begin
        // Unknown encodings fall through as a no-op
        dest       = rt;
        alu_op     = mips_pkg::ALU_ADD;
        use_imm    = 1'b0;
        imm        = imm_sext;
        writes_reg = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        is_beq     = 1'b0;
        is_bne     = 1'b0;
        is_j       = 1'b0;
        is_jr      = 1'b0;

        case (opcode)
            mips_pkg::OP_R: begin
                dest       = instr[15:11];
                writes_reg = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_SLL:  alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRA:  alu_op = mips_pkg::ALU_SRA;
                    mips_pkg::FN_JR: begin
                        writes_reg = 1'b0;
                        is_jr      = 1'b1;
                    end
                    default: writes_reg = 1'b0;
                endcase
            end
            mips_pkg::OP_J:   is_j = 1'b1;
            // Branches compare rs with rt, so b stays on the register
            mips_pkg::OP_BEQ: is_beq = 1'b1;
            mips_pkg::OP_BNE: is_bne = 1'b1;
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU: begin
                use_imm    = 1'b1;
                writes_reg = 1'b1;
                alu_op     = (opcode == mips_pkg::OP_SLTI)  ? mips_pkg::ALU_SLT :
                             (opcode == mips_pkg::OP_SLTIU) ? mips_pkg::ALU_SLTU :
                                                              mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
                use_imm    = 1'b1;
                imm        = imm_zext;
                writes_reg = 1'b1;
                alu_op     = (opcode == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND :
                             (opcode == mips_pkg::OP_ORI)  ? mips_pkg::ALU_OR :
                             (opcode == mips_pkg::OP_XORI) ? mips_pkg::ALU_XOR :
                                                             mips_pkg::ALU_LUI;
            end
            // Effective address is rs plus the offset through the adder
            mips_pkg::OP_LW: begin
                use_imm = 1'b1;
                is_load = 1'b1;
            end
            mips_pkg::OP_SW: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module mips_alu (
    input  mips_pkg::alu_op_t          op,
    input  wire logic [`MIPS_XLEN-1:0] a,
    input  wire logic [`MIPS_XLEN-1:0] b,
    input  wire logic [4:0]            shamt,
    output logic      [`MIPS_XLEN-1:0] result,
    output logic                       equal
);

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: begin
                result = a + b;
            end
            mips_pkg::ALU_SUB: begin
                result = a - b;
            end
            mips_pkg::ALU_AND: begin
                result = a & b;
            end
            mips_pkg::ALU_OR: begin
                result = a | b;
            end
            mips_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            mips_pkg::ALU_SLT: begin
                result = {{(`MIPS_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            end
            mips_pkg::ALU_SLTU: begin
                result = {{(`MIPS_XLEN-1){1'b0}}, a < b};
            end
            // Shifts act on rt, which arrives on b
            mips_pkg::ALU_SLL: begin
                result = b << shamt;
            end
            mips_pkg::ALU_SRL: begin
                result = b >> shamt;
            end
            mips_pkg::ALU_SRA: begin
                result = $signed(b) >>> shamt;
            end
            mips_pkg::ALU_LUI: begin
                result = {b[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Branch compare of rs against rt
    assign equal = (a == b);

endmodule

`default_nettype wire

//--- logic/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_consts.svh"

module mips_regfile (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic [`MIPS_RADDR_W-1:0] ra_addr,
    input  wire logic [`MIPS_RADDR_W-1:0] rb_addr,
    input  wire logic [`MIPS_RADDR_W-1:0] wr_addr,
    input  wire logic                     we,
    input  wire logic [`MIPS_XLEN-1:0]    wr_data,
    output logic      [`MIPS_XLEN-1:0]    ra_data,
    output logic      [`MIPS_XLEN-1:0]    rb_data,
    output logic      [`MIPS_XLEN-1:0]    v0
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin
            // $zero never takes a write
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous read ports
    assign ra_data = regs[ra_addr];
    assign rb_data = regs[rb_addr];

    assign v0 = regs[`MIPS_REG_V0];

endmodule

`default_nettype wire

//--- logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_R     = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function code, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC1 = 2'd1,
        EXEC2 = 2'd2,
        HALT  = 2'd3
    } state_t;

endpackage

`default_nettype wire

//--- logic/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Data path and address width
`define MIPS_XLEN 32

// Register file geometry
`define MIPS_NREGS 32
`define MIPS_RADDR_W 5

// First fetch after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Jumping here stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

// Result register $v0 and return address register $ra
`define MIPS_REG_V0 5'd2
`define MIPS_REG_RA 5'd31

`endif
